// File: source/nes_shell_pkg.sv
package nes_shell_pkg;

  // cartridge memory address width, 1 KiB
  localparam int MEM_ADDR_W = 10;

  // widths that carry a meaning
  typedef logic [MEM_ADDR_W-1:0] cart_addr_t;
  typedef logic [8:0] save_addr_t;
  typedef logic [7:0] byte_t;

  // save window is the upper half of cart memory
  localparam cart_addr_t SAVE_BASE = cart_addr_t'(512);

  // one pad, bit 0 up: a, b, select, start, up, down, left, right
  typedef logic [7:0] pad_buttons_t;

  // four pads, p1 in the low byte
  typedef struct packed {
    pad_buttons_t p4;
    pad_buttons_t p3;
    pad_buttons_t p2;
    pad_buttons_t p1;
  } pad_set_t;

  // controller lines as the console drives them
  typedef struct packed {
    logic       strobe;
    // one clock per port
    logic [1:0] clocks;
  } joy_bus_t;

  // multitap signature bytes, shifted out after the second pad
  localparam byte_t TAP_SIG_PORT1 = 8'h08;
  localparam byte_t TAP_SIG_PORT2 = 8'h04;

  // wishbone classic, master to slave
  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    cart_addr_t adr;
    byte_t      dat_w;
  } wb_req_t;

  // wishbone classic, slave to master
  typedef struct packed {
    logic  ack;
    byte_t dat_r;
  } wb_rsp_t;

  // reset sequencer states
  typedef enum logic [1:0] {
    HOLD_INIT,
    LOADING,
    COUNTDOWN,
    RUN
  } rst_state_e;

endpackage

// File: source/reset_sequencer.sv
`timescale 1ns/1ps

module reset_sequencer #(
  parameter int unsigned RESET_HOLD = 255
) (
  input  logic clk_ppu_21_47,
  input  logic reset_nes,
  input  logic ioctl_download,
  input  logic loader_busy,
  output logic core_reset
);

  // wide enough for RESET_HOLD, at least one bit
  localparam int CNT_W = $clog2(RESET_HOLD + 2);

  nes_shell_pkg::rst_state_e state_q;
  nes_shell_pkg::rst_state_e state_next;
  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_next;

  // reload during download, count only while loader idle
  always_comb begin
    cnt_next = cnt_q;
    if (ioctl_download) begin
      cnt_next = CNT_W'(RESET_HOLD);
    end else if (!loader_busy && cnt_q != '0) begin
      cnt_next = cnt_q - 1'b1;
    end
  end

  always_comb begin
    state_next = state_q;
    case (state_q)
      // machine held until the first download begins
      nes_shell_pkg::HOLD_INIT: begin
        if (ioctl_download) begin
          state_next = nes_shell_pkg::LOADING;
        end
      end
      nes_shell_pkg::LOADING, nes_shell_pkg::COUNTDOWN: begin
        if (ioctl_download) begin
          state_next = nes_shell_pkg::LOADING;
        end else if (cnt_next == '0) begin
          // release lines up with the counter hitting zero
          state_next = nes_shell_pkg::RUN;
        end else begin
          state_next = nes_shell_pkg::COUNTDOWN;
        end
      end
      nes_shell_pkg::RUN: begin
        // a new download resets the core again
        if (ioctl_download) begin
          state_next = nes_shell_pkg::LOADING;
        end
      end
      default: state_next = nes_shell_pkg::HOLD_INIT;
    endcase
  end

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      state_q    <= nes_shell_pkg::HOLD_INIT;
      cnt_q      <= '0;
      core_reset <= 1'b1;
    end else begin
      state_q    <= state_next;
      cnt_q      <= cnt_next;
      core_reset <= (state_next != nes_shell_pkg::RUN);
    end
  end

  // core only leaves reset in RUN with the countdown spent
  a_reset_outside_run : assert property (
    @(posedge clk_ppu_21_47) disable iff (reset_nes)
      !core_reset |-> (state_q == nes_shell_pkg::RUN && cnt_q == '0)
  );

endmodule

// File: source/joypad_serializer.sv
`timescale 1ns/1ps

module joypad_serializer (
  input  logic                    clk_ppu_21_47,
  input  logic                    core_reset,
  input  nes_shell_pkg::pad_set_t pads,
  input  logic                    multitap_enabled,
  input  nes_shell_pkg::joy_bus_t joy,
  output logic [1:0]              joy_data
);

  // per port: pad, then tap pad, then signature
  logic [1:0][23:0] shift_q;
  logic [1:0][23:0] load_val;
  // previous clock levels for edge detect
  logic [1:0]       last_clk_q;
  logic [1:0]       clk_fall;

  always_comb begin
    if (multitap_enabled) begin
      load_val[0] = {nes_shell_pkg::TAP_SIG_PORT1, pads.p3, pads.p1};
      load_val[1] = {nes_shell_pkg::TAP_SIG_PORT2, pads.p4, pads.p2};
    end else begin
      // no tap, reads past the pad return ones
      load_val[0] = {16'hffff, pads.p1};
      load_val[1] = {16'hffff, pads.p2};
    end
  end

  // high to low on the console clock line
  assign clk_fall = last_clk_q & ~joy.clocks;

  always_ff @(posedge clk_ppu_21_47) begin
    if (core_reset) begin
      shift_q    <= '0;
      last_clk_q <= '0;
    end else begin
      for (int n = 0; n < 2; n++) begin
        // strobe reloads, a falling clock still shifts
        if (joy.strobe) begin
          shift_q[n] <= load_val[n];
        end
        if (clk_fall[n]) begin
          shift_q[n] <= {1'b0, shift_q[n][23:1]};
        end
      end
      last_clk_q <= joy.clocks;
    end
  end

  // serial data is bit 0 of each register
  assign joy_data[0] = shift_q[0][0];
  assign joy_data[1] = shift_q[1][0];

endmodule

// File: source/rom_download_port.sv
`timescale 1ns/1ps

module rom_download_port (
  input  logic                   clk_ppu_21_47,
  input  logic                   reset_nes,
  input  logic                   ioctl_download,
  input  logic                   ioctl_wr,
  input  nes_shell_pkg::byte_t   ioctl_dout,
  output nes_shell_pkg::wb_req_t bus_req,
  input  nes_shell_pkg::wb_rsp_t bus_rsp,
  output logic                   loader_busy
);

  // next byte goes here
  nes_shell_pkg::cart_addr_t addr_q;
  logic                      download_q;
  logic                      download_rise;
  logic                      byte_in;

  assign download_rise = ioctl_download && !download_q;
  assign byte_in       = ioctl_wr && ioctl_download;

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      bus_req.cyc <= 1'b0;
      bus_req.stb <= 1'b0;
      addr_q      <= '0;
      download_q  <= 1'b0;
    end else begin
      download_q <= ioctl_download;
      if (byte_in && !bus_req.cyc) begin
        // one write per byte, the first byte may share the start cycle
        bus_req.cyc <= 1'b1;
        bus_req.stb <= 1'b1;
      end else if (bus_rsp.ack) begin
        bus_req.cyc <= 1'b0;
        bus_req.stb <= 1'b0;
        // wraps at the memory size
        addr_q      <= bus_req.adr + 1'b1;
      end
      // new download starts at address 0
      if (download_rise) begin
        addr_q <= '0;
      end
    end
  end

  // payload, held until ack
  always_ff @(posedge clk_ppu_21_47) begin
    if (byte_in && !bus_req.cyc) begin
      bus_req.we    <= 1'b1;
      bus_req.adr   <= download_rise ? '0 : addr_q;
      bus_req.dat_w <= ioctl_dout;
    end
  end

  // busy from the latched byte through ack
  assign loader_busy = bus_req.cyc;

  // host spacing must cover the bus latency
  a_byte_spacing : assert property (
    @(posedge clk_ppu_21_47) disable iff (reset_nes) byte_in |-> !loader_busy
  );

endmodule

// File: source/save_buffer_port.sv
`timescale 1ns/1ps

module save_buffer_port (
  input  logic                      clk_ppu_21_47,
  input  logic                      reset_nes,
  input  logic                      sd_buff_wr,
  input  logic                      sd_buff_rd,
  input  nes_shell_pkg::save_addr_t sd_buff_addr,
  input  nes_shell_pkg::byte_t      sd_buff_dout,
  output nes_shell_pkg::byte_t      sd_buff_din,
  output logic                      save_busy,
  output nes_shell_pkg::wb_req_t    bus_req,
  input  nes_shell_pkg::wb_rsp_t    bus_rsp
);

  logic                      req_in;
  nes_shell_pkg::cart_addr_t save_adr;

  // requests while busy are dropped
  assign req_in = (sd_buff_wr || sd_buff_rd) && !bus_req.cyc;

  // offset into the upper half of cart memory
  assign save_adr = nes_shell_pkg::SAVE_BASE + nes_shell_pkg::cart_addr_t'(sd_buff_addr);

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      bus_req.cyc <= 1'b0;
      bus_req.stb <= 1'b0;
    end else if (req_in) begin
      bus_req.cyc <= 1'b1;
      bus_req.stb <= 1'b1;
    end else if (bus_rsp.ack) begin
      bus_req.cyc <= 1'b0;
      bus_req.stb <= 1'b0;
    end
  end

  always_ff @(posedge clk_ppu_21_47) begin
    if (req_in) begin
      // write wins when both pulse
      bus_req.we    <= sd_buff_wr;
      bus_req.adr   <= save_adr;
      bus_req.dat_w <= sd_buff_dout;
    end
    // read data held until the next read completes
    if (bus_rsp.ack && !bus_req.we) begin
      sd_buff_din <= bus_rsp.dat_r;
    end
  end

  // high the cycle after the request, low the cycle after ack
  assign save_busy = bus_req.cyc;

endmodule

// File: source/cart_mem_arbiter.sv
`timescale 1ns/1ps

module cart_mem_arbiter (
  input  logic                   clk_ppu_21_47,
  input  logic                   reset_nes,
  input  nes_shell_pkg::wb_req_t load_req,
  output nes_shell_pkg::wb_rsp_t load_rsp,
  input  nes_shell_pkg::wb_req_t save_req,
  output nes_shell_pkg::wb_rsp_t save_rsp,
  output nes_shell_pkg::wb_req_t mem_req,
  input  nes_shell_pkg::wb_rsp_t mem_rsp
);

  typedef enum logic [1:0] {
    GNT_NONE,
    GNT_LOAD,
    GNT_SAVE
  } grant_e;

  grant_e grant_q;
  grant_e grant_sel;

  always_comb begin
    // current owner keeps the bus while its cyc is high
    if (grant_q == GNT_LOAD && load_req.cyc) begin
      grant_sel = GNT_LOAD;
    end else if (grant_q == GNT_SAVE && save_req.cyc) begin
      grant_sel = GNT_SAVE;
    end else if (load_req.cyc) begin
      // idle, loader first
      grant_sel = GNT_LOAD;
    end else if (save_req.cyc) begin
      grant_sel = GNT_SAVE;
    end else begin
      grant_sel = GNT_NONE;
    end
  end

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      grant_q <= GNT_NONE;
    end else begin
      grant_q <= grant_sel;
    end
  end

  // slave port follows the grant, idle bus is all zero
  always_comb begin
    case (grant_sel)
      GNT_LOAD: mem_req = load_req;
      GNT_SAVE: mem_req = save_req;
      default:  mem_req = '0;
    endcase
  end

  // the loser sees no ack and keeps stb up
  assign load_rsp.ack   = mem_rsp.ack && (grant_sel == GNT_LOAD);
  assign load_rsp.dat_r = mem_rsp.dat_r;
  assign save_rsp.ack   = mem_rsp.ack && (grant_sel == GNT_SAVE);
  assign save_rsp.dat_r = mem_rsp.dat_r;

  // ack lands one cycle after the granted strobe, grant must not have moved
  a_load_ack_granted : assert property (
    @(posedge clk_ppu_21_47) disable iff (reset_nes) load_rsp.ack |-> grant_q == GNT_LOAD
  );
  a_save_ack_granted : assert property (
    @(posedge clk_ppu_21_47) disable iff (reset_nes) save_rsp.ack |-> grant_q == GNT_SAVE
  );

endmodule

// File: source/cart_ram.sv
`timescale 1ns/1ps

module cart_ram (
  input  logic                   clk_ppu_21_47,
  input  logic                   reset_nes,
  input  nes_shell_pkg::wb_req_t bus_req,
  output nes_shell_pkg::wb_rsp_t bus_rsp
);

  localparam int DEPTH = 2 ** nes_shell_pkg::MEM_ADDR_W;

  // whole cart, save window in the upper half
  nes_shell_pkg::byte_t mem [DEPTH];

  logic access;

  // new access, not the strobe still held during ack
  assign access = bus_req.cyc && bus_req.stb && !bus_rsp.ack;

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      bus_rsp.ack <= 1'b0;
    end else begin
      // single cycle ack, one after stb
      bus_rsp.ack <= access;
    end
  end

  always_ff @(posedge clk_ppu_21_47) begin
    if (access && bus_req.we) begin
      mem[bus_req.adr] <= bus_req.dat_w;
    end
    // read data valid with ack
    if (access) begin
      bus_rsp.dat_r <= mem[bus_req.adr];
    end
  end

  // strobe only inside a bus cycle
  a_stb_in_cyc : assert property (
    @(posedge clk_ppu_21_47) disable iff (reset_nes) bus_req.stb |-> bus_req.cyc
  );

endmodule

// File: source/nes_shell.sv
`timescale 1ns/1ps

module nes_shell #(
  // post-download reset length in cycles
  parameter int unsigned RESET_HOLD = 255
) (
  input  logic                      clk_ppu_21_47,
  input  logic                      reset_nes,
  // rom download
  input  logic                      ioctl_download,
  input  logic                      ioctl_wr,
  input  nes_shell_pkg::byte_t      ioctl_dout,
  // save buffer
  input  logic                      sd_buff_wr,
  input  logic                      sd_buff_rd,
  input  nes_shell_pkg::save_addr_t sd_buff_addr,
  input  nes_shell_pkg::byte_t      sd_buff_dout,
  output nes_shell_pkg::byte_t      sd_buff_din,
  output logic                      save_busy,
  // controllers
  input  nes_shell_pkg::pad_set_t   pads,
  input  logic                      multitap_enabled,
  input  nes_shell_pkg::joy_bus_t   joy,
  output logic [1:0]                joy_data,
  output logic                      core_reset
);

  logic                   loader_busy;
  nes_shell_pkg::wb_req_t load_req;
  nes_shell_pkg::wb_rsp_t load_rsp;
  nes_shell_pkg::wb_req_t save_req;
  nes_shell_pkg::wb_rsp_t save_rsp;
  nes_shell_pkg::wb_req_t mem_req;
  nes_shell_pkg::wb_rsp_t mem_rsp;

  reset_sequencer #(
    .RESET_HOLD(RESET_HOLD)
  ) i_reset_sequencer (
    .clk_ppu_21_47 (clk_ppu_21_47),
    .reset_nes     (reset_nes),
    .ioctl_download(ioctl_download),
    .loader_busy   (loader_busy),
    .core_reset    (core_reset)
  );

  // pads are cleared by the core reset
  joypad_serializer i_joypad_serializer (
    .clk_ppu_21_47   (clk_ppu_21_47),
    .core_reset      (core_reset),
    .pads            (pads),
    .multitap_enabled(multitap_enabled),
    .joy             (joy),
    .joy_data        (joy_data)
  );

  rom_download_port i_rom_download_port (
    .clk_ppu_21_47 (clk_ppu_21_47),
    .reset_nes     (reset_nes),
    .ioctl_download(ioctl_download),
    .ioctl_wr      (ioctl_wr),
    .ioctl_dout    (ioctl_dout),
    .bus_req       (load_req),
    .bus_rsp       (load_rsp),
    .loader_busy   (loader_busy)
  );

  save_buffer_port i_save_buffer_port (
    .clk_ppu_21_47(clk_ppu_21_47),
    .reset_nes    (reset_nes),
    .sd_buff_wr   (sd_buff_wr),
    .sd_buff_rd   (sd_buff_rd),
    .sd_buff_addr (sd_buff_addr),
    .sd_buff_dout (sd_buff_dout),
    .sd_buff_din  (sd_buff_din),
    .save_busy    (save_busy),
    .bus_req      (save_req),
    .bus_rsp      (save_rsp)
  );

  // both peers share the one cart memory
  cart_mem_arbiter i_cart_mem_arbiter (
    .clk_ppu_21_47(clk_ppu_21_47),
    .reset_nes    (reset_nes),
    .load_req     (load_req),
    .load_rsp     (load_rsp),
    .save_req     (save_req),
    .save_rsp     (save_rsp),
    .mem_req      (mem_req),
    .mem_rsp      (mem_rsp)
  );

  cart_ram i_cart_ram (
    .clk_ppu_21_47(clk_ppu_21_47),
    .reset_nes    (reset_nes),
    .bus_req      (mem_req),
    .bus_rsp      (mem_rsp)
  );

endmodule

// File: test/nes_shell_tb.sv
`timescale 1ns/1ps

module nes_shell_tb;

  localparam int unsigned HOLD_CYCLES = 255;
  localparam int SAVE_BASE_ADDR = 512;
  localparam int MEM_DEPTH = 1024;
  // 520 downloads at 5 cycles, two countdowns, pads and saves, with margin
  localparam int MAX_CYCLES = 20000;

  logic                      clk_ppu_21_47;
  logic                      reset_nes;
  logic                      ioctl_download;
  logic                      ioctl_wr;
  nes_shell_pkg::byte_t      ioctl_dout;
  logic                      sd_buff_wr;
  logic                      sd_buff_rd;
  nes_shell_pkg::save_addr_t sd_buff_addr;
  nes_shell_pkg::byte_t      sd_buff_dout;
  nes_shell_pkg::byte_t      sd_buff_din;
  logic                      save_busy;
  nes_shell_pkg::pad_set_t   pads;
  logic                      multitap_enabled;
  nes_shell_pkg::joy_bus_t   joy;
  logic [1:0]                joy_data;
  logic                      core_reset;

  // expected cart memory contents
  nes_shell_pkg::byte_t      mem_model [MEM_DEPTH];
  logic [31:0]               lfsr_state;
  int                        cycle_count;
  int                        error_count;
  nes_shell_pkg::save_addr_t save_offs [8];
  logic [31:0]               rnd;
  logic [31:0]               rnd_data;

  nes_shell #(
    .RESET_HOLD(HOLD_CYCLES)
  ) i_dut (
    .*
  );

  always #5 clk_ppu_21_47 = ~clk_ppu_21_47;

  // hard stop on a hung handshake
  always @(posedge clk_ppu_21_47) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("ERRORS FOUND");
      $fatal(1, "simulation stopped by the cycle limit");
    end
  end

  // x^32 + x^22 + x^2 + x + 1, new bit enters at bit 0
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic fb;
    fb = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], fb};
  endfunction

  // one lfsr step per bit taken
  task automatic random_bits(input int nbits, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
  endtask

  // save offset lands above the rom area
  function automatic nes_shell_pkg::cart_addr_t save_cart_addr(
    input nes_shell_pkg::save_addr_t off
  );
    return nes_shell_pkg::cart_addr_t'(SAVE_BASE_ADDR + int'(off));
  endfunction

  // bit k of a port's serial stream after strobe
  function automatic logic pad_stream_bit(input int port, input int k,
                                          input nes_shell_pkg::pad_set_t p, input logic tap);
    logic [23:0] seq;
    if (tap) begin
      seq = (port == 0) ? {8'h08, p.p3, p.p1} : {8'h04, p.p4, p.p2};
    end else begin
      // no tap, reads past the pad give ones
      seq = (port == 0) ? {16'hffff, p.p1} : {16'hffff, p.p2};
    end
    if (k > 23) begin
      return 1'b0;
    end
    return seq[5'(k)];
  endfunction

  // core_reset n cycles after the first idle cycle past a download
  function automatic logic expected_core_reset(input int unsigned n);
    return n < HOLD_CYCLES;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // one host save request, returns once the port is idle
  task automatic save_access(input logic write, input nes_shell_pkg::save_addr_t off,
                             input nes_shell_pkg::byte_t data);
    @(posedge clk_ppu_21_47);
    sd_buff_wr   <= write;
    sd_buff_rd   <= !write;
    sd_buff_addr <= off;
    sd_buff_dout <= data;
    @(posedge clk_ppu_21_47);
    sd_buff_wr <= 1'b0;
    sd_buff_rd <= 1'b0;
    @(negedge clk_ppu_21_47);
    check_value("save busy after request", 32'(1'b1), 32'(save_busy));
    while (save_busy) begin
      @(negedge clk_ppu_21_47);
    end
    if (write) begin
      mem_model[save_cart_addr(off)] = data;
    end
  endtask

  // n random bytes, a save write shares byte save_at when it is in range
  task automatic download(input int n, input int save_at,
                          input nes_shell_pkg::save_addr_t save_off,
                          input nes_shell_pkg::byte_t save_dat);
    logic [31:0] value;
    nes_shell_pkg::cart_addr_t load_addr;
    load_addr = '0;
    @(posedge clk_ppu_21_47);
    ioctl_download <= 1'b1;
    for (int i = 0; i < n; i++) begin
      random_bits(8, value);
      @(posedge clk_ppu_21_47);
      ioctl_wr   <= 1'b1;
      ioctl_dout <= value[7:0];
      if (i == save_at) begin
        sd_buff_wr   <= 1'b1;
        sd_buff_addr <= save_off;
        sd_buff_dout <= save_dat;
        mem_model[save_cart_addr(save_off)] = save_dat;
      end
      mem_model[load_addr] = value[7:0];
      load_addr = load_addr + 1'b1;
      @(posedge clk_ppu_21_47);
      ioctl_wr   <= 1'b0;
      sd_buff_wr <= 1'b0;
      if (i == n - 1) begin
        // last write still in flight when the download ends
        ioctl_download <= 1'b0;
      end else begin
        repeat (4) begin
          @(negedge clk_ppu_21_47);
          check_value("core_reset during download", 32'(1'b1), 32'(core_reset));
        end
      end
    end
  endtask

  // countdown waits out the two busy cycles of the last write
  task automatic check_release();
    int unsigned n;
    @(negedge clk_ppu_21_47);
    repeat (2) begin
      check_value("core_reset while loader busy", 32'(1'b1), 32'(core_reset));
      @(negedge clk_ppu_21_47);
    end
    for (n = 0; n <= HOLD_CYCLES; n++) begin
      check_value("core_reset countdown", 32'(expected_core_reset(n)), 32'(core_reset));
      @(negedge clk_ppu_21_47);
    end
  endtask

  // strobe, then clock each port through its whole stream
  task automatic check_pads(input logic tap);
    logic [31:0] value;
    random_bits(32, value);
    @(posedge clk_ppu_21_47);
    pads             <= value;
    multitap_enabled <= tap;
    joy.strobe       <= 1'b1;
    @(posedge clk_ppu_21_47);
    joy.strobe <= 1'b0;
    for (int port = 0; port < 2; port++) begin
      for (int k = 0; k < 25; k++) begin
        @(negedge clk_ppu_21_47);
        check_value(tap ? "multitap stream" : "pad stream",
                    32'(pad_stream_bit(port, k, pads, tap)), 32'(joy_data[port[0]]));
        if (k < 24) begin
          @(posedge clk_ppu_21_47);
          joy.clocks[port[0]] <= 1'b1;
          @(posedge clk_ppu_21_47);
          joy.clocks[port[0]] <= 1'b0;
          @(posedge clk_ppu_21_47);
        end
      end
    end
  endtask

  initial begin
    clk_ppu_21_47    = 1'b0;
    reset_nes        = 1'b1;
    ioctl_download   = 1'b0;
    ioctl_wr         = 1'b0;
    ioctl_dout       = '0;
    sd_buff_wr       = 1'b0;
    sd_buff_rd       = 1'b0;
    sd_buff_addr     = '0;
    sd_buff_dout     = '0;
    pads             = '0;
    multitap_enabled = 1'b0;
    joy              = '0;
    lfsr_state       = 32'h77e0;
    cycle_count      = 0;
    error_count      = 0;
    repeat (3) @(posedge clk_ppu_21_47);
    reset_nes <= 1'b0;

    // held in reset until the first download
    repeat (10) begin
      @(negedge clk_ppu_21_47);
      check_value("core_reset before download", 32'(1'b1), 32'(core_reset));
    end

    // rom bytes 512 up show through the save window
    download(520, -1, '0, '0);
    check_release();
    for (int i = 0; i < 8; i++) begin
      save_access(1'b0, 9'(i), '0);
      check_value("save read after download", 32'(mem_model[save_cart_addr(9'(i))]),
                  32'(sd_buff_din));
    end

    // pads only run once core_reset is low
    check_pads(1'b0);
    check_pads(1'b1);

    // random save writes, then read back
    for (int i = 0; i < 8; i++) begin
      random_bits(9, rnd);
      random_bits(8, rnd_data);
      save_offs[i] = rnd[8:0];
      save_access(1'b1, rnd[8:0], rnd_data[7:0]);
    end
    for (int i = 0; i < 8; i++) begin
      save_access(1'b0, save_offs[i], '0);
      check_value("save read back", 32'(mem_model[save_cart_addr(save_offs[i])]),
                  32'(sd_buff_din));
    end

    // second request while busy must be dropped
    random_bits(8, rnd_data);
    @(posedge clk_ppu_21_47);
    sd_buff_wr   <= 1'b1;
    sd_buff_addr <= 9'd0;
    sd_buff_dout <= rnd_data[7:0];
    @(posedge clk_ppu_21_47);
    sd_buff_wr <= 1'b0;
    @(negedge clk_ppu_21_47);
    check_value("save busy before extra request", 32'(1'b1), 32'(save_busy));
    @(posedge clk_ppu_21_47);
    sd_buff_wr   <= 1'b1;
    sd_buff_addr <= 9'd3;
    sd_buff_dout <= ~mem_model[save_cart_addr(9'd3)];
    @(negedge clk_ppu_21_47);
    check_value("save busy during extra request", 32'(1'b1), 32'(save_busy));
    @(posedge clk_ppu_21_47);
    sd_buff_wr <= 1'b0;
    while (save_busy) begin
      @(negedge clk_ppu_21_47);
    end
    mem_model[save_cart_addr(9'd0)] = rnd_data[7:0];
    save_access(1'b0, 9'd0, '0);
    check_value("dropped request neighbour", 32'(mem_model[SAVE_BASE_ADDR]), 32'(sd_buff_din));
    save_access(1'b0, 9'd3, '0);
    check_value("dropped request target", 32'(mem_model[SAVE_BASE_ADDR + 3]),
                32'(sd_buff_din));

    // save write competing with a download for the bus
    random_bits(9, rnd);
    random_bits(8, rnd_data);
    download(24, 10, rnd[8:0], rnd_data[7:0]);
    check_release();
    save_access(1'b0, rnd[8:0], '0);
    check_value("save write during download", 32'(rnd_data[7:0]), 32'(sd_buff_din));

    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: nes_shell.f
source/nes_shell_pkg.sv
source/reset_sequencer.sv
source/joypad_serializer.sv
source/rom_download_port.sv
source/save_buffer_port.sv
source/cart_mem_arbiter.sv
source/cart_ram.sv
source/nes_shell.sv
test/nes_shell_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert --x-initial unique \
  --top-module nes_shell_tb -f nes_shell.f --Mdir "$build_dir" -o nes_shell_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

# registers power up as ones before the first reset edge
"$build_dir/nes_shell_sim" +verilator+rand+reset+1 > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "NO ERRORS" "$log_file"; then
  exit 0
fi
echo "pass message not found in $log_file"
exit 1
